/* hdl/tdd_pkg.sv */
package tdd_pkg;

  // ****************************************
  // fixed widths and constants
  // ****************************************

  localparam int TDD_CNT_WIDTH    = 32;
  localparam int TDD_ADDR_WIDTH   = 8;
  localparam int TDD_DATA_WIDTH   = 32;
  localparam int TDD_MAX_CHANNELS = 16;

  // major.minor.patch packed as 16/8/8
  localparam logic [31:0] TDD_VERSION = 32'h0001_0061;
  // ascii "TDDN"
  localparam logic [31:0] TDD_MAGIC   = 32'h5444_444e;

  typedef logic [TDD_CNT_WIDTH-1:0] tdd_cnt_t;

  // ****************************************
  // enums
  // ****************************************

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_ARMED   = 2'd1,
    ST_WAITING = 2'd2,
    ST_RUNNING = 2'd3
  } state_t;

  // word addresses with channel i at ADDR_CH_ON/OFF + 2*i
  typedef enum logic [TDD_ADDR_WIDTH-1:0] {
    ADDR_VERSION        = 8'h00,
    ADDR_ID             = 8'h01,
    ADDR_SCRATCH        = 8'h02,
    ADDR_IDENTIFICATION = 8'h03,
    ADDR_INTERFACE      = 8'h10,
    ADDR_CONTROL        = 8'h12,
    ADDR_CH_ENABLE      = 8'h13,
    ADDR_CH_POLARITY    = 8'h14,
    ADDR_BURST_COUNT    = 8'h15,
    ADDR_STARTUP_DELAY  = 8'h16,
    ADDR_FRAME_LENGTH   = 8'h17,
    ADDR_STATUS         = 8'h1a,
    ADDR_CH_ON          = 8'h20,
    ADDR_CH_OFF         = 8'h21
  } reg_addr_t;

  // ****************************************
  // structs
  // ****************************************

  typedef struct packed {
    logic enable;
    logic sync_soft;
  } tdd_ctrl_t;

  typedef struct packed {
    tdd_cnt_t burst_count;
    tdd_cnt_t startup_delay;
    tdd_cnt_t frame_length;
  } tdd_timing_t;

  typedef struct packed {
    logic     running;
    tdd_cnt_t count;
  } tdd_frame_t;

endpackage

/* hdl/tdd_cfg_regs.sv */
`timescale 1ns/1ps

module tdd_cfg_regs #(
  parameter int CHANNEL_COUNT = 4
) (
  input  logic                                 up_clk,
  input  logic                                 up_rstn,
  input  logic                                 up_wreq,
  input  tdd_pkg::reg_addr_t                   up_waddr,
  input  logic [tdd_pkg::TDD_DATA_WIDTH-1:0]   up_wdata,
  output logic                                 up_wack,
  output tdd_pkg::tdd_ctrl_t                   ctrl,
  output tdd_pkg::tdd_timing_t                 timing,
  output logic [CHANNEL_COUNT-1:0]             ch_en,
  output logic [CHANNEL_COUNT-1:0]             ch_pol,
  output tdd_pkg::tdd_cnt_t [CHANNEL_COUNT-1:0] ch_on,
  output tdd_pkg::tdd_cnt_t [CHANNEL_COUNT-1:0] ch_off,
  output logic [tdd_pkg::TDD_DATA_WIDTH-1:0]   scratch
);

  import tdd_pkg::*;

  // write strobe for the registers that are frozen while enabled
  logic wr_unlocked;

  assign wr_unlocked = up_wreq & ~ctrl.enable;

  if (CHANNEL_COUNT < 1 || CHANNEL_COUNT > TDD_MAX_CHANNELS) begin : g_bad_count
    $error("CHANNEL_COUNT out of range");
  end

  // ****************************************
  // always writable registers
  // ****************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack <= 1'b0;
      ctrl    <= '0;
      scratch <= '0;
      ch_en   <= '0;
    end else begin
      up_wack        <= up_wreq;
      ctrl.sync_soft <= 1'b0;
      if (up_wreq && up_waddr == ADDR_SCRATCH) begin
        scratch <= up_wdata;
      end
      if (up_wreq && up_waddr == ADDR_CONTROL) begin
        ctrl.enable    <= up_wdata[0];
        ctrl.sync_soft <= up_wdata[4];
      end
      if (up_wreq && up_waddr == ADDR_CH_ENABLE) begin
        ch_en <= up_wdata[CHANNEL_COUNT-1:0];
      end
    end
  end

  // ****************************************
  // timing registers, locked when enabled
  // ****************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      ch_pol <= '0;
      timing <= '0;
    end else if (wr_unlocked) begin
      case (up_waddr)
        ADDR_CH_POLARITY:   ch_pol               <= up_wdata[CHANNEL_COUNT-1:0];
        ADDR_BURST_COUNT:   timing.burst_count   <= up_wdata[TDD_CNT_WIDTH-1:0];
        ADDR_STARTUP_DELAY: timing.startup_delay <= up_wdata[TDD_CNT_WIDTH-1:0];
        ADDR_FRAME_LENGTH:  timing.frame_length  <= up_wdata[TDD_CNT_WIDTH-1:0];
        default: ;
      endcase
    end
  end

  // per channel on/off compare pair
  for (genvar i = 0; i < CHANNEL_COUNT; i++) begin : g_ch
    tdd_cnt_t on_q;
    tdd_cnt_t off_q;

    always_ff @(posedge up_clk) begin
      if (!up_rstn) begin
        on_q  <= '0;
        off_q <= '0;
      end else if (wr_unlocked) begin
        if (8'(up_waddr) == 8'(ADDR_CH_ON + 2 * i)) begin
          on_q <= up_wdata[TDD_CNT_WIDTH-1:0];
        end
        if (8'(up_waddr) == 8'(ADDR_CH_OFF + 2 * i)) begin
          off_q <= up_wdata[TDD_CNT_WIDTH-1:0];
        end
      end
    end

    assign ch_on[i]  = on_q;
    assign ch_off[i] = off_q;
  end

  // the frame engine sees one sync per request
  a_sync_single: assert property (@(posedge up_clk) disable iff (!up_rstn)
    ctrl.sync_soft |=> !ctrl.sync_soft);

endmodule

/* hdl/tdd_up_read.sv */
`timescale 1ns/1ps

module tdd_up_read #(
  parameter int          CHANNEL_COUNT = 4,
  parameter logic [31:0] ID            = 32'd0
) (
  input  logic                                 up_clk,
  input  logic                                 up_rstn,
  input  logic                                 up_rreq,
  input  tdd_pkg::reg_addr_t                   up_raddr,
  output logic [tdd_pkg::TDD_DATA_WIDTH-1:0]   up_rdata,
  output logic                                 up_rack,
  input  tdd_pkg::tdd_ctrl_t                   ctrl,
  input  tdd_pkg::tdd_timing_t                 timing,
  input  logic [CHANNEL_COUNT-1:0]             ch_en,
  input  logic [CHANNEL_COUNT-1:0]             ch_pol,
  input  tdd_pkg::tdd_cnt_t [CHANNEL_COUNT-1:0] ch_on,
  input  tdd_pkg::tdd_cnt_t [CHANNEL_COUNT-1:0] ch_off,
  input  logic [tdd_pkg::TDD_DATA_WIDTH-1:0]   scratch,
  input  tdd_pkg::state_t                      state
);

  import tdd_pkg::*;

  logic [TDD_DATA_WIDTH-1:0] rdata_s;

  // ****************************************
  // read mux
  // ****************************************

  always_comb begin
    rdata_s = '0;
    case (up_raddr)
      ADDR_VERSION:        rdata_s = TDD_VERSION;
      ADDR_ID:             rdata_s = ID;
      ADDR_SCRATCH:        rdata_s = scratch;
      ADDR_IDENTIFICATION: rdata_s = TDD_MAGIC;
      ADDR_INTERFACE:      rdata_s = {16'd0, 8'(TDD_CNT_WIDTH), 3'd0, 5'(CHANNEL_COUNT - 1)};
      // sync_soft is a strobe and is never visible here
      ADDR_CONTROL:        rdata_s = {31'd0, ctrl.enable};
      ADDR_CH_ENABLE:      rdata_s = 32'(ch_en);
      ADDR_CH_POLARITY:    rdata_s = 32'(ch_pol);
      ADDR_BURST_COUNT:    rdata_s = 32'(timing.burst_count);
      ADDR_STARTUP_DELAY:  rdata_s = 32'(timing.startup_delay);
      ADDR_FRAME_LENGTH:   rdata_s = 32'(timing.frame_length);
      ADDR_STATUS:         rdata_s = {30'd0, state};
      default:             rdata_s = '0;
    endcase
    // channel pairs above CHANNEL_COUNT fall through as zero
    for (int i = 0; i < CHANNEL_COUNT; i++) begin
      if (8'(up_raddr) == 8'(ADDR_CH_ON + 2 * i)) begin
        rdata_s = 32'(ch_on[i]);
      end
      if (8'(up_raddr) == 8'(ADDR_CH_OFF + 2 * i)) begin
        rdata_s = 32'(ch_off[i]);
      end
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack  <= up_rreq;
      up_rdata <= up_rreq ? rdata_s : '0;
    end
  end

  a_rdata_idle: assert property (@(posedge up_clk) disable iff (!up_rstn)
    !up_rack |-> up_rdata == '0);

endmodule

/* hdl/tdd_frame_fsm.sv */
`timescale 1ns/1ps

module tdd_frame_fsm (
  input  logic                 up_clk,
  input  logic                 up_rstn,
  input  tdd_pkg::tdd_ctrl_t   ctrl,
  input  tdd_pkg::tdd_timing_t timing,
  output tdd_pkg::state_t      state,
  output tdd_pkg::tdd_frame_t  frame
);

  import tdd_pkg::*;

  tdd_cnt_t delay_cnt;
  tdd_cnt_t frame_cnt;
  tdd_cnt_t frames_done;
  tdd_cnt_t frame_cnt_next;
  tdd_cnt_t frames_done_next;
  logic     frame_wrap;
  logic     burst_done;

  assign frame_cnt_next   = frame_cnt + 1'b1;
  assign frames_done_next = frames_done + 1'b1;
  assign frame_wrap       = frame_cnt_next >= timing.frame_length;
  // burst count of zero means run forever
  assign burst_done       = (timing.burst_count != '0) &&
                            (frames_done_next == timing.burst_count);

  // ****************************************
  // tdd state machine
  // ****************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn || !ctrl.enable) begin
      state       <= ST_IDLE;
      delay_cnt   <= '0;
      frame_cnt   <= '0;
      frames_done <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          state <= ST_ARMED;
        end
        ST_ARMED: begin
          if (ctrl.sync_soft) begin
            state       <= ST_WAITING;
            delay_cnt   <= timing.startup_delay;
            frame_cnt   <= '0;
            frames_done <= '0;
          end
        end
        ST_WAITING: begin
          // counts down to one, so a zero delay still spends one cycle here
          if (delay_cnt <= tdd_cnt_t'(1)) begin
            state     <= ST_RUNNING;
            frame_cnt <= '0;
          end else begin
            delay_cnt <= delay_cnt - 1'b1;
          end
        end
        ST_RUNNING: begin
          if (frame_wrap) begin
            frame_cnt   <= '0;
            frames_done <= frames_done_next;
            if (burst_done) begin
              state <= ST_ARMED;
            end
          end else begin
            frame_cnt <= frame_cnt_next;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign frame.running = (state == ST_RUNNING);
  assign frame.count   = frame_cnt;

  a_count_in_frame: assert property (@(posedge up_clk) disable iff (!up_rstn)
    frame.running && timing.frame_length != '0 |-> frame.count < timing.frame_length);

endmodule

/* hdl/tdd_ch_gen.sv */
`timescale 1ns/1ps

module tdd_ch_gen #(
  parameter int CHANNEL_COUNT = 4
) (
  input  logic                                 up_clk,
  input  logic                                 up_rstn,
  input  tdd_pkg::tdd_frame_t                  frame,
  input  logic [CHANNEL_COUNT-1:0]             ch_en,
  input  logic [CHANNEL_COUNT-1:0]             ch_pol,
  input  tdd_pkg::tdd_cnt_t [CHANNEL_COUNT-1:0] ch_on,
  input  tdd_pkg::tdd_cnt_t [CHANNEL_COUNT-1:0] ch_off,
  output logic [CHANNEL_COUNT-1:0]             tdd_channel
);

  import tdd_pkg::*;

  logic [CHANNEL_COUNT-1:0] window;

  // active window is [on, off), empty when off <= on
  for (genvar i = 0; i < CHANNEL_COUNT; i++) begin : g_win
    assign window[i] = frame.running & ch_en[i] &
                       (frame.count >= ch_on[i]) & (frame.count < ch_off[i]);
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      tdd_channel <= '0;
    end else begin
      tdd_channel <= ch_pol ^ window;
    end
  end

endmodule

/* hdl/tdd_ctrl_top.sv */
`timescale 1ns/1ps

module tdd_ctrl_top #(
  parameter int          CHANNEL_COUNT = 4,
  parameter logic [31:0] ID            = 32'd0
) (
  input  logic                               up_clk,
  input  logic                               up_rstn,
  input  logic                               up_wreq,
  input  logic [tdd_pkg::TDD_ADDR_WIDTH-1:0] up_waddr,
  input  logic [tdd_pkg::TDD_DATA_WIDTH-1:0] up_wdata,
  output logic                               up_wack,
  input  logic                               up_rreq,
  input  logic [tdd_pkg::TDD_ADDR_WIDTH-1:0] up_raddr,
  output logic [tdd_pkg::TDD_DATA_WIDTH-1:0] up_rdata,
  output logic                               up_rack,
  output logic [CHANNEL_COUNT-1:0]           tdd_channel
);

  import tdd_pkg::*;

  // ****************************************
  // interconnect
  // ****************************************

  tdd_ctrl_t                     ctrl;
  tdd_timing_t                   timing;
  logic [CHANNEL_COUNT-1:0]      ch_en;
  logic [CHANNEL_COUNT-1:0]      ch_pol;
  tdd_cnt_t [CHANNEL_COUNT-1:0]  ch_on;
  tdd_cnt_t [CHANNEL_COUNT-1:0]  ch_off;
  logic [TDD_DATA_WIDTH-1:0]     scratch;
  state_t                        state;
  tdd_frame_t                    frame;

  tdd_cfg_regs #(
    .CHANNEL_COUNT (CHANNEL_COUNT)
  ) cfg_regs_i (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .up_wreq  (up_wreq),
    .up_waddr (reg_addr_t'(up_waddr)),
    .up_wdata (up_wdata),
    .up_wack  (up_wack),
    .ctrl     (ctrl),
    .timing   (timing),
    .ch_en    (ch_en),
    .ch_pol   (ch_pol),
    .ch_on    (ch_on),
    .ch_off   (ch_off),
    .scratch  (scratch)
  );

  tdd_up_read #(
    .CHANNEL_COUNT (CHANNEL_COUNT),
    .ID            (ID)
  ) up_read_i (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .up_rreq  (up_rreq),
    .up_raddr (reg_addr_t'(up_raddr)),
    .up_rdata (up_rdata),
    .up_rack  (up_rack),
    .ctrl     (ctrl),
    .timing   (timing),
    .ch_en    (ch_en),
    .ch_pol   (ch_pol),
    .ch_on    (ch_on),
    .ch_off   (ch_off),
    .scratch  (scratch),
    .state    (state)
  );

  tdd_frame_fsm frame_fsm_i (
    .up_clk  (up_clk),
    .up_rstn (up_rstn),
    .ctrl    (ctrl),
    .timing  (timing),
    .state   (state),
    .frame   (frame)
  );

  tdd_ch_gen #(
    .CHANNEL_COUNT (CHANNEL_COUNT)
  ) ch_gen_i (
    .up_clk      (up_clk),
    .up_rstn     (up_rstn),
    .frame       (frame),
    .ch_en       (ch_en),
    .ch_pol      (ch_pol),
    .ch_on       (ch_on),
    .ch_off      (ch_off),
    .tdd_channel (tdd_channel)
  );

endmodule

/* verif/tdd_tb_bus.svh */
`ifndef TDD_TB_BUS_SVH
`define TDD_TB_BUS_SVH

// ****************************************
// bus access and channel waits
// ****************************************

// one cycle write strobe, then wait for the acknowledge
task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
  int waited;
  @(negedge up_clk);
  up_wreq  = 1'b1;
  up_waddr = addr;
  up_wdata = data;
  @(negedge up_clk);
  up_wreq = 1'b0;
  waited  = 0;
  while (!up_wack && waited < BUS_TIMEOUT) begin
    @(negedge up_clk);
    waited++;
  end
  if (!up_wack) begin
    $display("write to address 0x%02h was never acknowledged", addr);
    err_count++;
  end
endtask

// read data is taken in the cycle that carries up_rack
task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
  int waited;
  @(negedge up_clk);
  up_rreq  = 1'b1;
  up_raddr = addr;
  @(negedge up_clk);
  up_rreq = 1'b0;
  waited  = 0;
  while (!up_rack && waited < BUS_TIMEOUT) begin
    @(negedge up_clk);
    waited++;
  end
  data = up_rdata;
  if (!up_rack) begin
    $display("read from address 0x%02h was never acknowledged", addr);
    err_count++;
  end
endtask

// cycles counts the falling edges spent before the channel shows the level
task automatic wait_level(input int ch, input logic level, output int cycles);
  cycles = 0;
  while (tdd_channel[ch] !== level && cycles < EDGE_TIMEOUT) begin
    @(negedge up_clk);
    cycles++;
  end
  if (tdd_channel[ch] !== level) begin
    $display("channel %0d did not reach level %0b within %0d cycles", ch, level, EDGE_TIMEOUT);
    err_count++;
  end
endtask

`endif

/* verif/tdd_tb.sv */
`timescale 1ns/1ps

module tdd_tb;

  import tdd_pkg::*;

  localparam int          CH_COUNT     = 4;
  localparam int          BUS_TIMEOUT  = 16;
  localparam int          EDGE_TIMEOUT = 200;
  localparam int          STATUS_READS = 100;
  localparam int          IDLE_CH      = 2;
  localparam logic [3:0]  EN_INIT      = 4'b0001;
  localparam logic [3:0]  EN_LOCKED    = 4'b1011;
  localparam logic [3:0]  POL_INIT     = 4'b1000;
  localparam logic [31:0] START_DELAY  = 32'd5;
  localparam logic [31:0] RNG_SEED     = 32'hfb77_eb0a;

  logic                up_clk;
  logic                up_rstn;
  logic                up_wreq;
  logic [7:0]          up_waddr;
  logic [31:0]         up_wdata;
  logic                up_wack;
  logic                up_rreq;
  logic [7:0]          up_raddr;
  logic [31:0]         up_rdata;
  logic                up_rack;
  logic [CH_COUNT-1:0] tdd_channel;

  int          err_count;
  int          tests_run;
  int          tests_bad;
  int          test_start;
  int          ch0_rises;
  int          rises_at_start;
  int          high_len;
  int          period;
  logic        wreq_d;
  logic        rreq_d;
  logic        ch0_q;
  logic        idle_ch_check;
  logic [31:0] frame_len;
  logic [31:0] scratch_val;
  logic [31:0] win_on [CH_COUNT];
  logic [31:0] win_off [CH_COUNT];

  `include "tdd_tb_bus.svh"

  always #2 up_clk = ~up_clk;

  tdd_ctrl_top #(
    .CHANNEL_COUNT (CH_COUNT),
    .ID            (32'h5)
  ) dut_i (
    .up_clk      (up_clk),
    .up_rstn     (up_rstn),
    .up_wreq     (up_wreq),
    .up_waddr    (up_waddr),
    .up_wdata    (up_wdata),
    .up_wack     (up_wack),
    .up_rreq     (up_rreq),
    .up_raddr    (up_raddr),
    .up_rdata    (up_rdata),
    .up_rack     (up_rack),
    .tdd_channel (tdd_channel)
  );

  // request history and rising edges of channel 0
  always @(posedge up_clk) begin
    wreq_d <= up_wreq;
    rreq_d <= up_rreq;
    ch0_q  <= tdd_channel[0];
    if (up_rstn && tdd_channel[0] && !ch0_q) begin
      ch0_rises <= ch0_rises + 1;
    end
  end

  // ****************************************
  // protocol and channel assertions
  // ****************************************

  a_wack: assert property (@(posedge up_clk) disable iff (!up_rstn) up_wack == wreq_d)
    else begin
      $display("Error at %0t ns: up_wack expected %0b, got %0b",
               $time, $sampled(wreq_d), $sampled(up_wack));
      err_count++;
    end

  a_rack: assert property (@(posedge up_clk) disable iff (!up_rstn) up_rack == rreq_d)
    else begin
      $display("Error at %0t ns: up_rack expected %0b, got %0b",
               $time, $sampled(rreq_d), $sampled(up_rack));
      err_count++;
    end

  a_rdata_zero: assert property (@(posedge up_clk) disable iff (!up_rstn)
    !up_rack |-> up_rdata == 32'd0)
    else begin
      $display("Error at %0t ns: up_rdata expected 0x00000000, got 0x%08h",
               $time, $sampled(up_rdata));
      err_count++;
    end

  // a disabled channel sits at its polarity
  a_idle_ch: assert property (@(posedge up_clk) disable iff (!up_rstn)
    idle_ch_check |-> tdd_channel[IDLE_CH] == POL_INIT[IDLE_CH])
    else begin
      $display("Error at %0t ns: tdd_channel[%0d] expected %0b, got %0b", $time, IDLE_CH,
               POL_INIT[IDLE_CH], $sampled(tdd_channel[IDLE_CH]));
      err_count++;
    end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    a_value: assert (got == exp) else begin
      $display("Error at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, got);
      err_count++;
    end
  endtask

  task automatic check_read(input logic [7:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] got;
    bus_read(addr, got);
    check_value(name, exp, got);
  endtask

  // status register polled until it shows the wanted state
  task automatic poll_status(input logic [1:0] exp);
    logic [31:0] got;
    int          reads;
    reads = 0;
    got   = '1;
    while (got != {30'd0, exp} && reads < STATUS_READS) begin
      bus_read(ADDR_STATUS, got);
      reads++;
    end
    if (got != {30'd0, exp}) begin
      $display("status did not reach state %0d within %0d reads", exp, STATUS_READS);
      err_count++;
    end
  endtask

  task automatic start_frames();
    bus_write(ADDR_CONTROL, 32'h1);
    bus_write(ADDR_CONTROL, 32'h11);
    poll_status(ST_RUNNING);
  endtask

  // high and period measured from one real edge into the active level
  task automatic measure_window(input int ch, input logic active, output int high,
                                output int per);
    int lead;
    int low;
    wait_level(ch, ~active, lead);
    wait_level(ch, active, lead);
    wait_level(ch, ~active, high);
    wait_level(ch, active, low);
    per = high + low;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_count != test_start) begin
      tests_bad++;
      $display("%-18s : FAIL, %0d errors", name, err_count - test_start);
    end else begin
      $display("%-18s : ok", name);
    end
    test_start = err_count;
  endtask

  // ****************************************
  // stimulus
  // ****************************************

  initial begin
    void'($urandom(RNG_SEED));
    up_clk        = 1'b0;
    up_rstn       = 1'b0;
    up_wreq       = 1'b0;
    up_waddr      = '0;
    up_wdata      = '0;
    up_rreq       = 1'b0;
    up_raddr      = '0;
    err_count     = 0;
    tests_run     = 0;
    tests_bad     = 0;
    test_start    = 0;
    ch0_rises     = 0;
    idle_ch_check = 1'b0;
    frame_len     = 32'd8 + ($urandom % 33);
    scratch_val   = $urandom;
    for (int i = 0; i < CH_COUNT; i++) begin
      win_on[i]  = 32'd1 + ($urandom % (frame_len - 3));
      win_off[i] = win_on[i] + 32'd1 + ($urandom % (frame_len - 1 - win_on[i]));
    end
    repeat (16) @(posedge up_clk);
    @(negedge up_clk);
    up_rstn = 1'b1;

    // back to back requests for the strobe assertions
    check_value("tdd_channel", 32'd0, 32'(tdd_channel));
    @(negedge up_clk);
    up_wreq  = 1'b1;
    up_waddr = ADDR_SCRATCH;
    up_wdata = 32'h1;
    @(negedge up_clk);
    up_wdata = 32'h2;
    @(negedge up_clk);
    up_wreq  = 1'b0;
    up_rreq  = 1'b1;
    up_raddr = ADDR_SCRATCH;
    repeat (2) @(negedge up_clk);
    up_rreq = 1'b0;
    repeat (2) @(negedge up_clk);
    end_test("ack timing");

    check_read(ADDR_VERSION, TDD_VERSION, "up_rdata (VERSION)");
    check_read(ADDR_ID, 32'h5, "up_rdata (ID)");
    check_read(ADDR_IDENTIFICATION, TDD_MAGIC, "up_rdata (IDENTIFICATION)");
    check_read(ADDR_INTERFACE, (32'd32 << 8) | 32'(CH_COUNT - 1), "up_rdata (INTERFACE)");
    bus_write(ADDR_SCRATCH, scratch_val);
    check_read(ADDR_SCRATCH, scratch_val, "up_rdata (SCRATCH)");
    check_read(8'h05, 32'd0, "up_rdata (unmapped)");
    check_read(8'h20 + 8'(2 * CH_COUNT), 32'd0, "up_rdata (channel above count)");
    end_test("fixed reads");

    bus_write(ADDR_FRAME_LENGTH, frame_len);
    bus_write(ADDR_STARTUP_DELAY, START_DELAY);
    bus_write(ADDR_CH_POLARITY, 32'(POL_INIT));
    bus_write(ADDR_CH_ENABLE, 32'(EN_INIT));
    for (int i = 0; i < CH_COUNT; i++) begin
      bus_write(8'h20 + 8'(2 * i), win_on[i]);
      bus_write(8'h21 + 8'(2 * i), win_off[i]);
    end
    bus_write(ADDR_CONTROL, 32'h1);
    bus_write(ADDR_FRAME_LENGTH, frame_len + 32'd3);
    bus_write(ADDR_CH_ON, win_on[0] + 32'd1);
    bus_write(ADDR_CH_OFF, win_off[0] + 32'd1);
    bus_write(ADDR_CH_POLARITY, 32'(~POL_INIT));
    bus_write(ADDR_CH_ENABLE, 32'(EN_LOCKED));
    check_read(ADDR_FRAME_LENGTH, frame_len, "up_rdata (FRAME_LENGTH)");
    check_read(ADDR_CH_ON, win_on[0], "up_rdata (CH_ON 0)");
    check_read(ADDR_CH_OFF, win_off[0], "up_rdata (CH_OFF 0)");
    check_read(ADDR_CH_POLARITY, 32'(POL_INIT), "up_rdata (CH_POLARITY)");
    check_read(ADDR_CH_ENABLE, 32'(EN_LOCKED), "up_rdata (CH_ENABLE)");
    check_read(ADDR_CONTROL, 32'h1, "up_rdata (CONTROL)");
    end_test("lock rule");

    check_read(ADDR_STATUS, 32'(ST_ARMED), "up_rdata (STATUS armed)");
    bus_write(ADDR_CONTROL, 32'h11);
    poll_status(ST_RUNNING);
    check_read(ADDR_CONTROL, 32'h1, "up_rdata (CONTROL after sync)");
    bus_write(ADDR_CONTROL, 32'h0);
    check_read(ADDR_STATUS, 32'(ST_IDLE), "up_rdata (STATUS idle)");
    end_test("state sequence");

    start_frames();
    idle_ch_check = 1'b1;
    for (int ch = 0; ch < CH_COUNT; ch++) begin
      if (EN_LOCKED[ch]) begin
        measure_window(ch, ~POL_INIT[ch], high_len, period);
        check_value($sformatf("tdd_channel[%0d] window", ch), win_off[ch] - win_on[ch],
                    32'(high_len));
        check_value($sformatf("tdd_channel[%0d] period", ch), frame_len, 32'(period));
      end
    end
    idle_ch_check = 1'b0;
    bus_write(ADDR_CONTROL, 32'h0);
    end_test("channel waveform");

    for (int n = 1; n <= 3; n++) begin
      bus_write(ADDR_BURST_COUNT, 32'(n));
      bus_write(ADDR_CONTROL, 32'h1);
      rises_at_start = ch0_rises;
      bus_write(ADDR_CONTROL, 32'h11);
      poll_status(ST_ARMED);
      check_value("tdd_channel[0] windows", 32'(n), 32'(ch0_rises - rises_at_start));
      rises_at_start = ch0_rises;
      repeat (2 * frame_len) @(negedge up_clk);
      check_value("tdd_channel[0] windows after burst", 32'(rises_at_start),
                  32'(ch0_rises));
      bus_write(ADDR_CONTROL, 32'h0);
    end
    end_test("burst");

    $display("tests run: %0d, tests with errors: %0d, total errors: %0d",
             tests_run, tests_bad, err_count);
    if (err_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+verif
hdl/tdd_pkg.sv
hdl/tdd_cfg_regs.sv
hdl/tdd_up_read.sv
hdl/tdd_frame_fsm.sv
hdl/tdd_ch_gen.sv
hdl/tdd_ctrl_top.sv
verif/tdd_tb.sv

/* Makefile */
# Verilator build and run of the TDD controller testbench

VERILATOR ?= verilator
TOP       ?= tdd_tb
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard hdl/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): sources.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP) -f sources.f

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "test failed" $(LOG); then echo "failure found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
